//--- alignCombine.sv
`default_nettype none

module alignCombine import hybridPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 strobe,
    input  pathT                 paths,
    output logic [OUT_WIDTH-1:0] out,
    output logic                 outStrobe,
    input  logic                 valid
);

    localparam int POS_LIMIT = (1 << (OUT_WIDTH - 1)) - 1;
    localparam int NEG_LIMIT = -(1 << (OUT_WIDTH - 1));

    logic signed [ACC_WIDTH-1:0] backDelayed;
    logic signed [ACC_WIDTH-1:0] aheadScaled;
    logic signed [ACC_WIDTH-1:0] backScaled;
    logic signed [ACC_WIDTH-1:0] sumReg;
    logic signed [OUT_WIDTH-1:0] clipped;

    // Lookback runs one strobe ahead of the LUT path
    assign aheadScaled = paths.ahead >>> AHEAD_SHIFT;
    assign backScaled = backDelayed >>> BACK_SHIFT;

    always_comb begin
        if (sumReg > POS_LIMIT) begin
            clipped = OUT_WIDTH'(POS_LIMIT);
        end else if (sumReg < NEG_LIMIT) begin
            clipped = OUT_WIDTH'(NEG_LIMIT);
        end else begin
            clipped = sumReg[OUT_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            backDelayed <= '0;
            sumReg <= '0;
            out <= '0;
            outStrobe <= 1'b0;
        end else begin
            outStrobe <= strobe && valid;
            if (strobe) begin
                backDelayed <= paths.back;
                sumReg <= aheadScaled + backScaled;
                // Offset binary
                out <= {~clipped[OUT_WIDTH-1], clipped[OUT_WIDTH-2:0]};
            end
        end
    end

endmodule

`default_nettype wire

//--- compile.f
hybridPkg.sv
inputWindow.sv
lookaheadLut.sv
lookbackRecursion.sv
alignCombine.sv
validCounter.sv
hybridFilter.sv
tbClock.sv
hybridFilter_assertions.sv
hybridFilterTb.sv

//--- hybridFilter.sv
`default_nettype none

module hybridFilter import hybridPkg::*; #(
    parameter int DSR = 4,
    parameter int DEPTH = 32
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 bitIn,
    output logic [OUT_WIDTH-1:0] out,
    output logic                 valid,
    output logic                 outStrobe
);

    windowT                      window;
    logic signed [ACC_WIDTH-1:0] aheadSum;
    logic signed [ACC_WIDTH-1:0] backState;
    pathT                        paths;

    if (DSR < 2 || DSR > MAX_DSR) begin : badDsr
        $error("DSR must lie between 2 and MAX_DSR");
    end

    if (DEPTH % DSR != 0 || DEPTH <= DSR || DEPTH > MAX_DEPTH || DEPTH % LUT_SIZE != 0)
    begin : badDepth
        $error("DEPTH must be a multiple of DSR and LUT_SIZE, up to MAX_DEPTH");
    end

    inputWindow #(.DSR(DSR), .DEPTH(DEPTH)) windowGen (
        .clk(clk), .rstN(rstN), .bitIn(bitIn), .window(window)
    );

    lookaheadLut #(.DEPTH(DEPTH)) aheadPath (
        .clk(clk), .rstN(rstN), .window(window), .aheadSum(aheadSum)
    );

    lookbackRecursion #(.DSR(DSR)) backPath (
        .clk(clk), .rstN(rstN), .window(window), .backState(backState)
    );

    validCounter #(.DSR(DSR), .DEPTH(DEPTH)) validGen (
        .clk(clk), .rstN(rstN), .strobe(window.strobe), .valid(valid)
    );

    assign paths.ahead = aheadSum;
    assign paths.back = backState;

    alignCombine combine (
        .clk(clk),
        .rstN(rstN),
        .strobe(window.strobe),
        .paths(paths),
        .out(out),
        .outStrobe(outStrobe),
        .valid(valid)
    );

endmodule

`default_nettype wire

//--- hybridFilterTb.sv
`default_nettype none

module hybridFilterTb import hybridPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DSR = 4;
    localparam int DEPTH = 32;
    localparam int FILL = DEPTH / DSR + PIPE_DELAY;
    // Output on strobe k reflects the window of strobe k-3
    localparam int OUT_LAG = 3;
    localparam int TOTAL_BITS = 120 + 120 + 80 + 400 + 120;
    localparam int CYCLE_LIMIT = 2 * TOTAL_BITS + DSR * FILL;
    localparam int OUT_OFFSET = 1 << (OUT_WIDTH - 1);

    logic                 clk;
    logic                 rstN;
    logic                 restart;
    logic                 bitIn;
    logic [OUT_WIDTH-1:0] out;
    logic                 valid;
    logic                 outStrobe;

    int seed;
    int samples[$];
    int backHist[$];
    int expQ[$];
    int blocks;
    int pushCount;
    int popCount;
    int dropped;
    int cycles;
    bit freeze;
    bit done;

    tbClock clkGen (.restart(restart), .clk(clk), .rstN(rstN));

    hybridFilter #(.DSR(DSR), .DEPTH(DEPTH)) dut_i (
        .clk(clk),
        .rstN(rstN),
        .bitIn(bitIn),
        .out(out),
        .valid(valid),
        .outStrobe(outStrobe)
    );

    task automatic checkValue(input int got, input int exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    // Bit i of the window after block j with bit 0 newest
    function automatic int windowBit(input int j, input int i);
        int n;
        n = j - i / DSR;
        if (n < 1) begin
            return 0;
        end
        return samples[DSR * n - 1 - i % DSR];
    endfunction

    function automatic int leaveSum(input int n);
        int m;
        int b;
        int sum;
        m = n - DEPTH / DSR;
        sum = 0;
        for (int pos = 0; pos < DSR; pos++) begin
            b = (m < 1) ? 0 : samples[DSR * m - 1 - pos];
            sum = b ? sum + int'(backWeight(pos)) : sum - int'(backWeight(pos));
        end
        return sum;
    endfunction

    function automatic int refOut(input int j);
        int ahead;
        int s;
        ahead = 0;
        for (int i = 0; i < DEPTH; i++) begin
            if (windowBit(j, i) != 0) begin
                ahead = ahead + int'(aheadCoeff(i, DEPTH));
            end else begin
                ahead = ahead - int'(aheadCoeff(i, DEPTH));
            end
        end
        s = (ahead >>> AHEAD_SHIFT) + (backHist[j] >>> BACK_SHIFT);
        if (s > OUT_OFFSET - 1) begin
            s = OUT_OFFSET - 1;
        end else if (s < -OUT_OFFSET) begin
            s = -OUT_OFFSET;
        end
        return s + OUT_OFFSET;
    endfunction

    // Model follows the sampled bits with one block per DSR clocks
    always @(posedge clk) begin
        if (!rstN) begin
            dropped = dropped + expQ.size();
            expQ.delete();
            samples.delete();
            backHist.delete();
            backHist.push_back(0);
            blocks = 0;
        end else if (!freeze) begin
            samples.push_back(int'(bitIn));
            if (samples.size() % DSR == 0) begin
                blocks = blocks + 1;
                backHist.push_back(backHist[blocks-1] - (backHist[blocks-1] >>> LEAK_SHIFT)
                    + leaveSum(blocks));
                if (blocks > FILL) begin
                    expQ.push_back(refOut(blocks - OUT_LAG));
                    pushCount = pushCount + 1;
                end
            end
        end
    end

    // Strobe k lands on the clock after sample DSR*k
    always @(negedge clk) begin
        if (!freeze) begin
            checkValue(int'(valid), int'(samples.size() > DSR * FILL), "valid");
            checkValue(int'(outStrobe),
                int'(samples.size() % DSR == 1 && samples.size() > DSR * (FILL + 1)),
                "outStrobe");
        end
        if (outStrobe && !done) begin
            if (expQ.size() == 0) begin
                checkValue(1, 0, "outStrobe with no expected value");
            end else begin
                checkValue(int'(out), expQ.pop_front(), "out");
                popCount = popCount + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Something failed");
            $fatal(1);
        end
    end

    task automatic driveBit(input logic b);
        @(posedge clk);
        #1;
        bitIn = b;
    endtask

    // kind 0 zeros, 1 ones, 2 alternating, 3 random
    task automatic drivePhase(input int kind, input int count);
        for (int i = 0; i < count; i++) begin
            case (kind)
                0: driveBit(1'b0);
                1: driveBit(1'b1);
                2: driveBit(i[0]);
                default: driveBit(1'($random(seed)));
            endcase
        end
    endtask

    initial begin
        bitIn = 1'b0;
        restart = 1'b0;
        seed = 32'hcd3a_9735;
        blocks = 0;
        pushCount = 0;
        popCount = 0;
        dropped = 0;
        cycles = 0;
        freeze = 1'b0;
        done = 1'b0;
        backHist.push_back(0);

        wait (rstN);
        drivePhase(1, 120);
        drivePhase(0, 120);
        drivePhase(2, 80);
        drivePhase(3, 400);

        // Reset in the middle of the run
        @(posedge clk);
        #1;
        restart = 1'b1;
        @(posedge clk);
        #1;
        restart = 1'b0;
        while (!rstN) begin
            @(posedge clk);
        end
        drivePhase(3, 120);

        freeze = 1'b1;
        while (expQ.size() != 0) begin
            @(posedge clk);
        end
        done = 1'b1;

        checkValue(popCount, pushCount - dropped, "output count");
        if (expQ.size() == 0 && popCount == pushCount - dropped) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Something failed");
            $fatal(1);
        end
    end

endmodule

bind hybridFilter hybridFilter_assertions #(.DSR(DSR)) assertChk (
    .clk(clk),
    .rstN(rstN),
    .valid(valid),
    .outStrobe(outStrobe)
);

`default_nettype wire

//--- hybridFilter_assertions.sv
`default_nettype none

module hybridFilter_assertions #(
    parameter int DSR = 4
) (
    input logic clk,
    input logic rstN,
    input logic valid,
    input logic outStrobe
);

    timeunit 1ns;
    timeprecision 100ps;

    // Valid must already be high whenever a pulse is out
    strobeNeedsValid: assert property (
        @(posedge clk) disable iff (!rstN) outStrobe |-> valid
    ) else $error("outStrobe raised while valid was low");

    strobeSpacing: assert property (
        @(posedge clk) disable iff (!rstN) outStrobe |=> !outStrobe [*(DSR-1)]
    ) else $error("outStrobe pulses closer than DSR clocks");

    validHolds: assert property (
        @(posedge clk) $fell(valid) |-> !$past(rstN)
    ) else $error("valid fell without a reset");

endmodule

`default_nettype wire

//--- hybridPkg.sv
`default_nettype none

package hybridPkg;

    localparam int LUT_SIZE = 4;
    localparam int LUT_ENTRIES = 1 << LUT_SIZE;
    localparam int COEFF_WIDTH = 12;
    localparam int ACC_WIDTH = 24;
    localparam int OUT_WIDTH = 12;
    localparam int LEAK_SHIFT = 4;
    localparam int BACK_SHIFT = 4;
    localparam int AHEAD_SHIFT = 2;
    localparam int PIPE_DELAY = 4;

    // Largest window and block the record can carry
    localparam int MAX_DEPTH = 32;
    localparam int MAX_DSR = 4;

    // Peak of the lookahead taper, at the newest bit
    localparam int COEFF_PEAK = 256;

    function automatic logic signed [COEFF_WIDTH-1:0] aheadCoeff(input int tap, input int depth);
        int value;
        value = (COEFF_PEAK * (depth - tap)) / depth;
        return COEFF_WIDTH'(value);
    endfunction

    // Position 0 is the newest bit of a block
    function automatic logic signed [COEFF_WIDTH-1:0] backWeight(input int pos);
        int value;
        value = 256 + 64 * pos;
        return COEFF_WIDTH'(value);
    endfunction

    typedef struct packed {
        logic                 strobe;
        logic [MAX_DEPTH-1:0] bits;
        logic [MAX_DSR-1:0]   leave;
    } windowT;

    typedef struct packed {
        logic signed [ACC_WIDTH-1:0] ahead;
        logic signed [ACC_WIDTH-1:0] back;
    } pathT;

    typedef enum logic {
        FILLING,
        RUNNING
    } validStateT;

endpackage

`default_nettype wire

//--- inputWindow.sv
`default_nettype none

module inputWindow import hybridPkg::*; #(
    parameter int DSR = 4,
    parameter int DEPTH = 32
) (
    input  logic   clk,
    input  logic   rstN,
    input  logic   bitIn,
    output windowT window
);

    localparam int CNT_WIDTH = $clog2(DSR);

    logic [CNT_WIDTH-1:0] phase;
    logic                 wrap;
    logic                 strobe;
    logic [DSR-2:0]       partial;
    logic [DSR-1:0]       newBlock;
    logic [DEPTH-1:0]     winBits;
    logic [DSR-1:0]       leaving;

    assign wrap = (phase == CNT_WIDTH'(DSR - 1));

    // Bit arriving on the wrap clock completes the block
    assign newBlock = {partial, bitIn};

    always_ff @(posedge clk) begin
        partial <= newBlock[DSR-2:0];
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            phase <= '0;
            strobe <= 1'b0;
            winBits <= '0;
            leaving <= '0;
        end else begin
            strobe <= wrap;
            if (wrap) begin
                phase <= '0;
                // Oldest block drops out as the new one enters at bit 0
                winBits <= {winBits[DEPTH-DSR-1:0], newBlock};
                leaving <= winBits[DEPTH-1 -: DSR];
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    always_comb begin
        window = '0;
        window.strobe = strobe;
        window.bits[DEPTH-1:0] = winBits;
        window.leave[DSR-1:0] = leaving;
    end

endmodule

`default_nettype wire

//--- lookaheadLut.sv
`default_nettype none

module lookaheadLut import hybridPkg::*; #(
    parameter int DEPTH = 32
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  windowT                      window,
    output logic signed [ACC_WIDTH-1:0] aheadSum
);

    localparam int GROUPS = DEPTH / LUT_SIZE;
    localparam int TABLE_WIDTH = LUT_ENTRIES * ACC_WIDTH;

    logic signed [ACC_WIDTH-1:0] groupVal [GROUPS];
    logic signed [ACC_WIDTH-1:0] groupReg [GROUPS];
    logic signed [ACC_WIDTH-1:0] treeSum;

    // Every entry sums +coeff for a one bit and -coeff for a zero bit
    function automatic logic [TABLE_WIDTH-1:0] buildTable(input int group);
        logic [TABLE_WIDTH-1:0] lutBits;
        int entry;
        int tap;
        lutBits = '0;
        for (int addr = 0; addr < LUT_ENTRIES; addr++) begin
            entry = 0;
            for (int j = 0; j < LUT_SIZE; j++) begin
                tap = group * LUT_SIZE + j;
                if (addr[j]) begin
                    entry = entry + int'(aheadCoeff(tap, DEPTH));
                end else begin
                    entry = entry - int'(aheadCoeff(tap, DEPTH));
                end
            end
            lutBits[addr*ACC_WIDTH +: ACC_WIDTH] = ACC_WIDTH'(entry);
        end
        return lutBits;
    endfunction

    for (genvar g = 0; g < GROUPS; g++) begin : groupLut
        localparam logic [TABLE_WIDTH-1:0] LUT = buildTable(g);
        logic [LUT_SIZE-1:0] addr;

        assign addr = window.bits[g*LUT_SIZE +: LUT_SIZE];
        assign groupVal[g] = LUT[addr*ACC_WIDTH +: ACC_WIDTH];
    end

    always_comb begin
        treeSum = '0;
        for (int g = 0; g < GROUPS; g++) begin
            treeSum = treeSum + groupReg[g];
        end
    end

    // Stage one
    always_ff @(posedge clk) begin
        if (window.strobe) begin
            groupReg <= groupVal;
        end
    end

    // Stage two
    always_ff @(posedge clk) begin
        if (!rstN) begin
            aheadSum <= '0;
        end else if (window.strobe) begin
            aheadSum <= treeSum;
        end
    end

endmodule

`default_nettype wire

//--- lookbackRecursion.sv
`default_nettype none

module lookbackRecursion import hybridPkg::*; #(
    parameter int DSR = 4
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  windowT                      window,
    output logic signed [ACC_WIDTH-1:0] backState
);

    logic signed [ACC_WIDTH-1:0] blockSum;
    logic signed [ACC_WIDTH-1:0] leak;
    logic signed [ACC_WIDTH-1:0] nextState;

    // Weighted sum of the block that just left the window
    always_comb begin
        blockSum = '0;
        for (int pos = 0; pos < DSR; pos++) begin
            if (window.leave[pos]) begin
                blockSum = blockSum + backWeight(pos);
            end else begin
                blockSum = blockSum - backWeight(pos);
            end
        end
    end

    // Leaky integrator, settles at blockSum << LEAK_SHIFT for a steady input
    assign leak = backState >>> LEAK_SHIFT;
    assign nextState = backState - leak + blockSum;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            backState <= '0;
        end else if (window.strobe) begin
            backState <= nextState;
        end
    end

endmodule

`default_nettype wire

//--- runSim.sh
#!/usr/bin/env bash
# Build and run the hybridFilter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module hybridFilterTb \
    -Mdir obj_dir \
    -f compile.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/VhybridFilterTb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

//--- tbClock.sv
`default_nettype none

module tbClock (
    input  logic restart,
    output logic clk,
    output logic rstN
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 5;

    int holdCnt;

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        holdCnt = RESET_CYCLES;
    end

    always #4 clk = ~clk;

    // Reset moves 2 ns after the edge, after the stimulus has settled
    always @(posedge clk) begin
        #2;
        if (restart) begin
            holdCnt = RESET_CYCLES;
        end else if (holdCnt != 0) begin
            holdCnt = holdCnt - 1;
        end
        rstN = (holdCnt == 0);
    end

endmodule

`default_nettype wire

//--- validCounter.sv
`default_nettype none

module validCounter import hybridPkg::*; #(
    parameter int DSR = 4,
    parameter int DEPTH = 32
) (
    input  logic clk,
    input  logic rstN,
    input  logic strobe,
    output logic valid
);

    // Window fill plus pipeline latency
    localparam int FILL = DEPTH / DSR + PIPE_DELAY;
    localparam int CNT_WIDTH = $clog2(FILL + 1);

    validStateT           state;
    logic [CNT_WIDTH-1:0] count;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= FILLING;
            count <= '0;
        end else if (strobe && state == FILLING) begin
            count <= count + 1'b1;
            if (count == CNT_WIDTH'(FILL - 1)) begin
                state <= RUNNING;
            end
        end
    end

    assign valid = (state == RUNNING);

endmodule

`default_nettype wire
